/* cam_pkg.sv */
`default_nettype none

package cam_pkg;

    // ====================
    // line geometry
    // ====================
    localparam int h_act  = 32; // active pixels per line.
    localparam int v_act  = 8;  // active lines per frame.
    localparam int n_cam  = 2;

    localparam int col_w  = $clog2(h_act);
    localparam int row_w  = $clog2(v_act);
    localparam int id_w   = (n_cam > 1) ? $clog2(n_cam) : 1;

    localparam int line_bytes = 3 * h_act; // red, green, blue per pixel.
    localparam int line_aw    = $clog2(line_bytes);

    localparam int gap_wait = h_act; // idle cycles between cameras.
    localparam int gap_w    = $clog2(gap_wait + 1);
    localparam int cnt_w    = 5;

    // ====================
    // pixel word
    // ====================
    typedef struct packed {
        logic [7:0]       red;
        logic [7:0]       green;
        logic [7:0]       blue;
        logic             de;  // pixel valid.
        logic             sol; // start of line.
        logic             eol; // end of line.
        logic             sof; // start of frame.
        logic [col_w-1:0] col;
        logic [row_w-1:0] row;
    } cam_pack_t;

    // ====================
    // read side
    // ====================
    typedef struct packed {
        logic [7:0]       data;
        logic [row_w-1:0] row;
        logic             aquire; // line ready to pop.
        logic             busy;
        logic             error;
    } line_out_t;

endpackage : cam_pkg

`default_nettype wire

/* line_swap_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module line_swap_ctrl (
    input  wire logic                     rclk,
    input  wire logic                     rstn,
    input  wire logic                     trig,
    input  wire logic [cam_pkg::n_cam-1:0] busy,
    output logic      [cam_pkg::n_cam-1:0] cam_trig,
    output logic      [cam_pkg::id_w-1:0]  cam_id,
    output logic      [cam_pkg::cnt_w-1:0] cnt
);

    typedef enum logic [1:0] {
        s_idle,
        s_arm,
        s_wait,
        s_gap
    } state_t;

    state_t                    state;
    logic                      trig_q;
    logic                      busy_cur;
    logic [cam_pkg::gap_w-1:0] gap_cnt;

    assign busy_cur = busy[cam_id]; // busy of the camera being served.

    // ====================
    // trigger latch
    // ====================
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            trig_q <= 1'b0;
        end else if (state != s_idle) begin
            trig_q <= 1'b0; // a trig during a round is dropped.
        end else if (trig) begin
            trig_q <= 1'b1;
        end
    end

    // ====================
    // round sequencer
    // ====================
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state    <= s_idle;
            cam_trig <= '0;
            cam_id   <= '0;
            cnt      <= '0;
            gap_cnt  <= '0;
        end else begin
            cam_trig <= '0;
            case (state)
                s_idle: begin
                    cam_id  <= '0;
                    gap_cnt <= '0;
                    if (trig_q) begin
                        cnt   <= cnt + 1'b1;
                        state <= s_arm;
                    end
                end
                s_arm: begin
                    if (busy_cur) begin
                        state <= s_wait; // buffer took the trigger.
                    end else begin
                        cam_trig[cam_id] <= 1'b1;
                    end
                end
                s_wait: begin
                    if (!busy_cur) begin
                        if (cam_id == cam_pkg::n_cam - 1) begin
                            state <= s_idle; // last camera done.
                        end else begin
                            gap_cnt <= '0;
                            state   <= s_gap;
                        end
                    end
                end
                s_gap: begin
                    if (gap_cnt != cam_pkg::gap_wait) begin
                        gap_cnt <= gap_cnt + 1'b1;
                        if (gap_cnt == cam_pkg::gap_wait - 1) begin
                            cam_id <= cam_id + 1'b1;
                        end
                    end else if (!busy_cur) begin
                        state <= s_arm;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

endmodule : line_swap_ctrl

`default_nettype wire

/* line_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module line_buffer (
    input  wire logic               rclk,
    input  wire logic               rstn,
    input  wire logic               trig,
    input  wire cam_pkg::cam_pack_t pack,
    input  wire logic               read_en,
    output cam_pkg::line_out_t      line_out
);

    typedef enum logic [1:0] {
        s_idle,
        s_sync,
        s_capt,
        s_read
    } state_t;

    state_t                      state;
    logic [cam_pkg::col_w-1:0]   exp_col;
    logic [cam_pkg::line_aw-1:0] rd_ptr;
    logic [cam_pkg::line_aw-1:0] wr_base;
    logic [7:0]                  mem [cam_pkg::line_bytes];
    logic [7:0]                  data_q;
    logic [cam_pkg::row_w-1:0]   row_q;
    logic                        err_q;

    logic sol_hit;
    logic wr_en;
    logic aquire;
    logic pop;
    logic col_err;
    logic rd_err;

    assign sol_hit = (state == s_sync) && pack.de && pack.sol;
    assign wr_en   = sol_hit || ((state == s_capt) && pack.de);
    assign wr_base = pack.col * 2'd3; // three bytes per pixel.

    assign aquire = (state == s_read);
    assign pop    = aquire && read_en;

    // sol must sit on col 0, then each pixel follows the previous one.
    assign col_err = (sol_hit && (pack.col != '0)) ||
                     ((state == s_capt) && pack.de && (pack.col != exp_col));
    assign rd_err  = read_en && !aquire;

    // ====================
    // capture and readout
    // ====================
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state   <= s_idle;
            exp_col <= '0;
            rd_ptr  <= '0;
            err_q   <= 1'b0;
        end else begin
            err_q <= col_err | rd_err;
            case (state)
                s_idle: begin
                    rd_ptr <= '0;
                    if (trig) begin
                        state <= s_sync;
                    end
                end
                s_sync: begin
                    if (sol_hit) begin
                        exp_col <= pack.col + 1'b1;
                        state   <= pack.eol ? s_read : s_capt;
                    end
                end
                s_capt: begin
                    if (pack.de) begin
                        exp_col <= exp_col + 1'b1;
                        if (pack.eol) begin
                            state <= s_read;
                        end
                    end
                end
                s_read: begin
                    if (pop) begin
                        rd_ptr <= rd_ptr + 1'b1;
                        if (rd_ptr == cam_pkg::line_bytes - 1) begin
                            state <= s_idle; // last byte gone, release busy.
                        end
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // ====================
    // line ram
    // ====================
    always_ff @(posedge rclk) begin
        if (wr_en) begin
            mem[wr_base]     <= pack.red;
            mem[wr_base + 1] <= pack.green;
            mem[wr_base + 2] <= pack.blue;
        end
        if (sol_hit) begin
            row_q <= pack.row;
        end
        if (pop) begin
            data_q <= mem[rd_ptr]; // byte valid one cycle after read_en.
        end
    end

    assign line_out = '{
        data:   data_q,
        row:    row_q,
        aquire: aquire,
        busy:   (state != s_idle),
        error:  err_q
    };

endmodule : line_buffer

`default_nettype wire

/* line_read_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module line_read_mux (
    input  wire logic                     rclk,
    input  wire logic                     rstn,
    input  wire logic [cam_pkg::id_w-1:0] cam_id,
    input  wire cam_pkg::line_out_t       line_out [cam_pkg::n_cam],
    output logic      [7:0]               cam_data,
    output logic      [cam_pkg::row_w-1:0] cam_row,
    output logic                          aquire,
    output logic                          error
);

    cam_pkg::line_out_t sel;
    logic               err_any;
    logic               error_q;

    // ====================
    // output select
    // ====================
    assign sel      = line_out[cam_id];
    assign cam_data = sel.data;
    assign cam_row  = sel.row;
    assign aquire   = sel.aquire;

    // any buffer counts, not only the one selected.
    always_comb begin
        err_any = 1'b0;
        for (int i = 0; i < cam_pkg::n_cam; i++) begin
            err_any = err_any | line_out[i].error;
        end
    end

    // ====================
    // sticky error
    // ====================
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            error_q <= 1'b0;
        end else if (err_any) begin
            error_q <= 1'b1; // held until reset.
        end
    end

    assign error = error_q;

endmodule : line_read_mux

`default_nettype wire

/* line_swap_top.sv */
`timescale 1ns/1ns
`default_nettype none

module line_swap_top (
    input  wire logic                      rclk,
    input  wire logic                      rstn,
    input  wire logic                      trig,
    input  wire cam_pkg::cam_pack_t        cam_pack [cam_pkg::n_cam],
    input  wire logic                      read_en,
    output logic      [7:0]                cam_data,
    output logic      [cam_pkg::row_w-1:0] cam_row,
    output logic      [cam_pkg::id_w-1:0]  cam_id,
    output logic                           aquire,
    output logic      [cam_pkg::cnt_w-1:0] cnt,
    output logic                           error
);

    logic [cam_pkg::n_cam-1:0] cam_trig;
    logic [cam_pkg::n_cam-1:0] busy;
    logic [cam_pkg::n_cam-1:0] buf_rd;
    cam_pkg::line_out_t        line_out [cam_pkg::n_cam];

    line_swap_ctrl line_swap_ctrl_inst (
        .rclk     (rclk),
        .rstn     (rstn),
        .trig     (trig),
        .busy     (busy),
        .cam_trig (cam_trig),
        .cam_id   (cam_id),
        .cnt      (cnt)
    );

    // ====================
    // one buffer per camera
    // ====================
    for (genvar g = 0; g < cam_pkg::n_cam; g++) begin : g_cam
        assign buf_rd[g] = read_en && (cam_id == g); // only the served camera pops.
        assign busy[g]   = line_out[g].busy;

        line_buffer line_buffer_inst (
            .rclk     (rclk),
            .rstn     (rstn),
            .trig     (cam_trig[g]),
            .pack     (cam_pack[g]),
            .read_en  (buf_rd[g]),
            .line_out (line_out[g])
        );
    end

    line_read_mux line_read_mux_inst (
        .rclk     (rclk),
        .rstn     (rstn),
        .cam_id   (cam_id),
        .line_out (line_out),
        .cam_data (cam_data),
        .cam_row  (cam_row),
        .aquire   (aquire),
        .error    (error)
    );

endmodule : line_swap_top

`default_nettype wire

/* tb_line_swap_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module line_swap_sva (
    input wire logic                      rclk,
    input wire logic                      rstn,
    input wire logic [cam_pkg::n_cam-1:0] cam_trig,
    input wire logic [cam_pkg::n_cam-1:0] busy,
    input wire logic [cam_pkg::id_w-1:0]  cam_id,
    input wire logic                      aquire,
    input wire logic                      error
);

    // ====================
    // sequencer
    // ====================
    a_trig_onehot: assert property (@(posedge rclk) disable iff (!rstn)
        $onehot0(cam_trig))
        else $error("cam_trig high for more than one camera");

    a_id_idle: assert property (@(posedge rclk) disable iff (!rstn)
        !$stable(cam_id) |-> (busy == '0))
        else $error("cam_id changed while a buffer was busy");

    // ====================
    // read side
    // ====================
    a_aquire_busy: assert property (@(posedge rclk) disable iff (!rstn)
        aquire |-> busy[cam_id])
        else $error("aquire high while the selected buffer is not busy");

    a_error_sticky: assert property (@(posedge rclk) disable iff (!rstn)
        error |=> error)
        else $error("error fell outside reset");

endmodule : line_swap_sva

bind line_swap_top line_swap_sva line_swap_sva_inst (
    .rclk     (rclk),
    .rstn     (rstn),
    .cam_trig (cam_trig),
    .busy     (busy),
    .cam_id   (cam_id),
    .aquire   (aquire),
    .error    (error)
);

`default_nettype wire

/* tb_line_swap.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_line_swap;

    localparam int wait_max = 2000; // cycles before a wait gives up.

    logic                        rclk;
    logic                        rstn;
    logic                        trig;
    logic                        read_en;
    wire cam_pkg::cam_pack_t     cam_pack [cam_pkg::n_cam];
    logic [7:0]                  cam_data;
    logic [cam_pkg::row_w-1:0]   cam_row;
    logic [cam_pkg::id_w-1:0]    cam_id;
    logic                        aquire;
    logic [cam_pkg::cnt_w-1:0]   cnt;
    logic                        error;

    int err_count;
    int err_mark;
    int test_pass;
    int test_fail;

    line_swap_top line_swap_top_inst (
        .rclk     (rclk),
        .rstn     (rstn),
        .trig     (trig),
        .cam_pack (cam_pack),
        .read_en  (read_en),
        .cam_data (cam_data),
        .cam_row  (cam_row),
        .cam_id   (cam_id),
        .aquire   (aquire),
        .cnt      (cnt),
        .error    (error)
    );

    initial begin
        rclk = 1'b0;
        forever #5 rclk = ~rclk;
    end

    // byte sel of pixel col in row where 0 is red, 1 green and 2 blue.
    function automatic logic [7:0] pixel_byte(input int cam, input int row,
                                              input int col, input int sel);
        logic [7:0] red;
        red = 8'(cam * 64 + col);
        case (sel)
            0:       return red;
            1:       return 8'(row * 16 + col % 16);
            default: return ~red;
        endcase
    endfunction

    // ====================
    // camera models
    // ====================
    for (genvar c = 0; c < cam_pkg::n_cam; c++) begin : g_cam_model
        int                 col;
        int                 row;
        int                 blank;
        cam_pkg::cam_pack_t pix;
        cam_pkg::cam_pack_t pix_q = '0;

        assign cam_pack[c] = pix_q;

        always @(posedge rclk) begin
            if (!rstn) begin
                col   <= 0;
                row   <= 0;
                blank <= 2;
                pix_q <= '0;
            end else if (blank > 0) begin
                blank <= blank - 1; // horizontal blank.
                pix_q <= '0;
            end else begin
                pix       = '0;
                pix.red   = pixel_byte(c, row, col, 0);
                pix.green = pixel_byte(c, row, col, 1);
                pix.blue  = pixel_byte(c, row, col, 2);
                pix.de    = 1'b1;
                pix.sol   = (col == 0);
                pix.eol   = (col == cam_pkg::h_act - 1);
                pix.sof   = (col == 0) && (row == 0);
                pix.col   = col[cam_pkg::col_w-1:0];
                pix.row   = row[cam_pkg::row_w-1:0];
                pix_q    <= pix;
                if (col == cam_pkg::h_act - 1) begin
                    col   <= 0;
                    row   <= (row + 1) % cam_pkg::v_act;
                    blank <= 2 + int'($urandom % 8); // 2 to 9 cycles.
                end else begin
                    col <= col + 1;
                end
            end
        end
    end

    // ====================
    // helpers
    // ====================
    task automatic flag_mismatch(input string msg);
        $display("error at %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic note_timeout(input string what);
        $display("timeout at %0t: %s within %0d cycles", $time, what, wait_max);
        err_count++;
    endtask

    task automatic apply_reset();
        @(posedge rclk);
        rstn    <= 1'b0;
        trig    <= 1'b0;
        read_en <= 1'b0;
        repeat (5) @(posedge rclk);
        rstn <= 1'b1;
        @(negedge rclk);
    endtask

    task automatic pulse_trig();
        @(posedge rclk);
        trig <= 1'b1;
        @(posedge rclk);
        trig <= 1'b0;
    endtask

    task automatic wait_aquire(output logic ok);
        int n;
        n = 0;
        @(negedge rclk);
        while (!aquire && n < wait_max) begin
            @(negedge rclk);
            n++;
        end
        ok = aquire;
        if (!ok) begin
            note_timeout("aquire did not rise");
        end
    endtask

    // pops one whole line and checks it against the pixel rule.
    task automatic read_line(input int cam);
        logic       ok;
        int         row;
        int         idle;
        logic [7:0] want;
        wait_aquire(ok);
        if (!ok) begin
            return;
        end
        if (cam_id != cam) begin
            flag_mismatch($sformatf("cam_id is %0d, expected %0d", cam_id, cam));
        end
        row = cam_row;
        for (int i = 0; i < cam_pkg::line_bytes; i++) begin
            idle = int'($urandom % 4);
            repeat (idle) @(negedge rclk);
            if (!aquire) begin
                flag_mismatch($sformatf("aquire fell after %0d bytes", i));
                return;
            end
            @(posedge rclk);
            read_en <= 1'b1;
            @(posedge rclk);
            read_en <= 1'b0;
            @(negedge rclk);
            want = pixel_byte(cam, row, i / 3, i % 3);
            if (cam_data !== want) begin
                flag_mismatch($sformatf("cam %0d row %0d byte %0d is %02h, expected %02h",
                                        cam, row, i, cam_data, want));
            end
        end
    endtask

    // the sequencer idles one edge after the last busy falls.
    task automatic wait_round_end();
        int n;
        n = 0;
        while (line_swap_top_inst.busy != '0 && n < wait_max) begin
            @(negedge rclk);
            n++;
        end
        if (line_swap_top_inst.busy != '0) begin
            note_timeout("buffers did not release busy");
        end
        @(posedge rclk);
        @(negedge rclk);
    endtask

    task automatic check_cnt(input int want);
        if (cnt != want) begin
            flag_mismatch($sformatf("cnt is %0d, expected %0d", cnt, want));
        end
    endtask

    task automatic end_test(input string name);
        if (err_count == err_mark) begin
            test_pass++;
            $display("test %s: ok", name);
        end else begin
            test_fail++;
            $display("test %s: failed with %0d errors", name, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic test_reset_values();
        if (aquire || error || cam_id != 0 || cnt != 0) begin
            flag_mismatch($sformatf("after reset aquire %0b error %0b cam_id %0d cnt %0d",
                                    aquire, error, cam_id, cnt));
        end
        end_test("reset_values");
    endtask

    task automatic test_cam0_line();
        pulse_trig();
        read_line(0);
        check_cnt(1);
        end_test("cam0_line");
    endtask

    task automatic test_cam1_line();
        read_line(1);
        wait_round_end();
        if (error) begin
            flag_mismatch("error set during a clean round");
        end
        end_test("cam1_line");
    endtask

    task automatic test_round_count();
        apply_reset();
        for (int r = 1; r <= 3; r++) begin
            pulse_trig();
            read_line(0);
            read_line(1);
            wait_round_end();
            check_cnt(r);
        end
        if (error) begin
            flag_mismatch("error set during clean rounds");
        end
        pulse_trig();
        read_line(0);
        wait_round_end();
        check_cnt(4);
        end_test("round_count");
    endtask

    task automatic test_dropped_trig();
        logic ok;
        apply_reset();
        pulse_trig();
        wait_aquire(ok);
        pulse_trig(); // lands during camera 0's line.
        read_line(0);
        read_line(1);
        wait_round_end();
        check_cnt(1);
        repeat (2 * cam_pkg::gap_wait) @(negedge rclk);
        check_cnt(1);
        if (aquire) begin
            flag_mismatch("aquire high with no round running");
        end
        end_test("dropped_trig");
    endtask

    task automatic test_error_path();
        int n;
        apply_reset();
        if (error) begin
            flag_mismatch("error high after reset");
        end
        @(posedge rclk);
        read_en <= 1'b1;
        @(posedge rclk);
        read_en <= 1'b0;
        n = 0;
        @(negedge rclk);
        while (!error && n < wait_max) begin
            @(negedge rclk);
            n++;
        end
        if (!error) begin
            note_timeout("error did not rise after a stray read_en");
        end
        for (int i = 0; i < 8; i++) begin
            @(negedge rclk);
            if (!error) begin
                flag_mismatch("error fell without reset");
            end
        end
        pulse_trig();
        read_line(0);
        read_line(1);
        wait_round_end();
        if (!error) begin
            flag_mismatch("error cleared by a later round");
        end
        end_test("error_path");
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        void'($urandom(32'hf4bd_6ca8));
        rstn      = 1'b0;
        trig      = 1'b0;
        read_en   = 1'b0;
        err_count = 0;
        err_mark  = 0;
        test_pass = 0;
        test_fail = 0;

        apply_reset();
        test_reset_values();
        test_cam0_line();
        test_cam1_line();
        test_round_count();
        test_dropped_trig();
        test_error_path();

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 test_pass + test_fail, test_pass, test_fail, err_count);
        if (test_fail == 0 && err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_line_swap

`default_nettype wire

/* verilog.f */
cam_pkg.sv
line_swap_ctrl.sv
line_buffer.sv
line_read_mux.sv
line_swap_top.sv
tb_line_swap_sva.sv
tb_line_swap.sv
